// ==== ex_pkg.sv ====
package ex_pkg;

    // Data path and field widths
    localparam int xlen   = 32;
    localparam int tag_w  = 8;   // Physical register tag
    localparam int ctrl_w = 7;
    localparam int op_w   = 7;
    localparam int f3_w   = 3;

    localparam logic [op_w-1:0] op_mul = 7'b0110011;  // Multiplier opcode

    // Control bit positions
    localparam int ctrl_branch = 0;  // Conditional branch
    localparam int ctrl_alt    = 1;  // SUB instead of ADD, SRA instead of SRL

    // Integer ALU func3
    localparam logic [f3_w-1:0] f3_add  = 3'b000;
    localparam logic [f3_w-1:0] f3_sll  = 3'b001;
    localparam logic [f3_w-1:0] f3_slt  = 3'b010;
    localparam logic [f3_w-1:0] f3_sltu = 3'b011;
    localparam logic [f3_w-1:0] f3_xor  = 3'b100;
    localparam logic [f3_w-1:0] f3_srl  = 3'b101;
    localparam logic [f3_w-1:0] f3_or   = 3'b110;
    localparam logic [f3_w-1:0] f3_and  = 3'b111;

    // Branch compare func3
    localparam logic [f3_w-1:0] f3_beq  = 3'b000;
    localparam logic [f3_w-1:0] f3_bne  = 3'b001;
    localparam logic [f3_w-1:0] f3_blt  = 3'b100;
    localparam logic [f3_w-1:0] f3_bge  = 3'b101;
    localparam logic [f3_w-1:0] f3_bltu = 3'b110;
    localparam logic [f3_w-1:0] f3_bgeu = 3'b111;

    // Multiply func3
    localparam logic [f3_w-1:0] f3_mul    = 3'b000;
    localparam logic [f3_w-1:0] f3_mulh   = 3'b001;  // Signed x signed
    localparam logic [f3_w-1:0] f3_mulhsu = 3'b010;  // Signed x unsigned
    localparam logic [f3_w-1:0] f3_mulhu  = 3'b011;  // Unsigned x unsigned

endpackage

// ==== ex_issue_if.sv ====
`timescale 1ns/10ps

interface ex_issue_if;

    logic                         valid;     // One-cycle issue strobe
    logic [ex_pkg::xlen-1:0]      operand1;
    logic [ex_pkg::xlen-1:0]      operand2;
    logic [ex_pkg::f3_w-1:0]      func3;
    logic [ex_pkg::xlen-1:0]      pc;
    logic [ex_pkg::xlen-1:0]      label;     // Branch immediate
    logic [ex_pkg::ctrl_w-1:0]    control;
    logic [ex_pkg::tag_w-1:0]     tag;       // Destination physical register

    // Dispatcher side
    modport src (
        output valid, operand1, operand2, func3, pc, label, control, tag
    );

    // Execution unit side
    modport dst (
        input valid, operand1, operand2, func3, pc, label, control, tag
    );

endinterface

// ==== ex_result_if.sv ====
`timescale 1ns/10ps

interface ex_result_if;

    logic                         valid;   // One-cycle completion strobe
    logic [ex_pkg::tag_w-1:0]     tag;
    logic [ex_pkg::xlen-1:0]      value;
    logic                         taken;   // Branches only
    logic [ex_pkg::xlen-1:0]      target;  // Branches only

    // Execution unit side
    modport src (
        output valid, tag, value, taken, target
    );

    // Merger side
    modport dst (
        input valid, tag, value, taken, target
    );

endinterface

// ==== ex_dispatch.sv ====
`timescale 1ns/10ps

module ex_dispatch (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       execute_on,
    input  logic [ex_pkg::op_w-1:0]    opcode,
    input  logic [ex_pkg::xlen-1:0]    operand1,
    input  logic [ex_pkg::xlen-1:0]    operand2,
    input  logic [ex_pkg::f3_w-1:0]    func3,
    input  logic [ex_pkg::xlen-1:0]    pc,
    input  logic [ex_pkg::xlen-1:0]    label,
    input  logic [ex_pkg::ctrl_w-1:0]  control,
    input  logic [ex_pkg::tag_w-1:0]   rd_tag,
    ex_issue_if.src                    alu_issue,
    ex_issue_if.src                    mul_issue
);

    logic to_mul;
    logic to_alu;

    assign to_mul = execute_on && (opcode == ex_pkg::op_mul);
    assign to_alu = execute_on && (opcode != ex_pkg::op_mul);  // All other opcodes

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            alu_issue.valid    <= 1'b0;
            alu_issue.operand1 <= '0;
            alu_issue.operand2 <= '0;
            alu_issue.func3    <= '0;
            alu_issue.pc       <= '0;
            alu_issue.label    <= '0;
            alu_issue.control  <= '0;
            alu_issue.tag      <= '0;
            mul_issue.valid    <= 1'b0;
            mul_issue.operand1 <= '0;
            mul_issue.operand2 <= '0;
            mul_issue.func3    <= '0;
            mul_issue.pc       <= '0;
            mul_issue.label    <= '0;
            mul_issue.control  <= '0;
            mul_issue.tag      <= '0;
        end else begin
            alu_issue.valid <= to_alu;
            mul_issue.valid <= to_mul;
            if (to_alu) begin
                alu_issue.operand1 <= operand1;
                alu_issue.operand2 <= operand2;
                alu_issue.func3    <= func3;
                alu_issue.pc       <= pc;
                alu_issue.label    <= label;
                alu_issue.control  <= control;
                alu_issue.tag      <= rd_tag;
            end
            if (to_mul) begin
                mul_issue.operand1 <= operand1;
                mul_issue.operand2 <= operand2;
                mul_issue.func3    <= func3;
                mul_issue.pc       <= pc;
                mul_issue.label    <= label;
                mul_issue.control  <= control;
                mul_issue.tag      <= rd_tag;
            end
        end
    end

    a_issue_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(alu_issue.valid && mul_issue.valid));

endmodule

// ==== int_alu.sv ====
`timescale 1ns/10ps

module int_alu (
    input  logic       clk,
    input  logic       reset,
    ex_issue_if.dst    issue,
    ex_result_if.src   result
);

    logic [ex_pkg::xlen-1:0] a;
    logic [ex_pkg::xlen-1:0] b;
    logic [4:0]              shamt;      // Low bits of operand2
    logic [ex_pkg::xlen-1:0] sra_out;
    logic [ex_pkg::xlen-1:0] alu_out;
    logic                    cmp_taken;
    logic                    is_branch;
    logic                    alt;

    assign a         = issue.operand1;
    assign b         = issue.operand2;
    assign shamt     = issue.operand2[4:0];
    assign sra_out   = $signed(a) >>> shamt;
    assign is_branch = issue.control[ex_pkg::ctrl_branch];
    assign alt       = issue.control[ex_pkg::ctrl_alt];

    always_comb begin
        case (issue.func3)
            ex_pkg::f3_add:  alu_out = alt ? a - b : a + b;
            ex_pkg::f3_sll:  alu_out = a << shamt;
            ex_pkg::f3_slt:  alu_out = {{(ex_pkg::xlen-1){1'b0}}, $signed(a) < $signed(b)};
            ex_pkg::f3_sltu: alu_out = {{(ex_pkg::xlen-1){1'b0}}, a < b};
            ex_pkg::f3_xor:  alu_out = a ^ b;
            ex_pkg::f3_srl:  alu_out = alt ? sra_out : a >> shamt;
            ex_pkg::f3_or:   alu_out = a | b;
            default:         alu_out = a & b;  // f3_and
        endcase
    end

    always_comb begin
        case (issue.func3)
            ex_pkg::f3_beq:  cmp_taken = (a == b);
            ex_pkg::f3_bne:  cmp_taken = (a != b);
            ex_pkg::f3_blt:  cmp_taken = $signed(a) < $signed(b);
            ex_pkg::f3_bge:  cmp_taken = $signed(a) >= $signed(b);
            ex_pkg::f3_bltu: cmp_taken = a < b;
            ex_pkg::f3_bgeu: cmp_taken = a >= b;
            default:         cmp_taken = 1'b0;  // Undefined compare never branches
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            result.valid  <= 1'b0;
            result.tag    <= '0;
            result.value  <= '0;
            result.taken  <= 1'b0;
            result.target <= '0;
        end else begin
            result.valid <= issue.valid;
            if (issue.valid) begin
                result.tag    <= issue.tag;
                result.value  <= is_branch ? issue.pc + 4 : alu_out;  // Link value
                result.taken  <= is_branch && cmp_taken;
                result.target <= is_branch ? issue.pc + issue.label : '0;
            end
        end
    end

endmodule

// ==== mul_unit.sv ====
`timescale 1ns/10ps

module mul_unit (
    input  logic       clk,
    input  logic       reset,
    ex_issue_if.dst    issue,
    ex_result_if.src   result
);

    logic signed [ex_pkg::xlen:0]     a_ext;      // One extra bit for the sign
    logic signed [ex_pkg::xlen:0]     b_ext;
    logic signed [2*ex_pkg::xlen+1:0] prod_full;
    logic                             a_signed;
    logic                             b_signed;

    // Stage 1 registers
    logic                             s1_valid;
    logic [2*ex_pkg::xlen-1:0]        s1_prod;
    logic [ex_pkg::tag_w-1:0]         s1_tag;
    logic [ex_pkg::f3_w-1:0]          s1_func3;

    assign a_signed  = (issue.func3 == ex_pkg::f3_mulh) || (issue.func3 == ex_pkg::f3_mulhsu);
    assign b_signed  = (issue.func3 == ex_pkg::f3_mulh);
    assign a_ext     = {a_signed && issue.operand1[ex_pkg::xlen-1], issue.operand1};
    assign b_ext     = {b_signed && issue.operand2[ex_pkg::xlen-1], issue.operand2};
    assign prod_full = a_ext * b_ext;

    // No branch outcome from this unit
    assign result.taken  = 1'b0;
    assign result.target = '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s1_valid     <= 1'b0;
            s1_prod      <= '0;
            s1_tag       <= '0;
            s1_func3     <= '0;
            result.valid <= 1'b0;
            result.tag   <= '0;
            result.value <= '0;
        end else begin
            s1_valid     <= issue.valid;
            result.valid <= s1_valid;
            if (issue.valid) begin
                s1_prod  <= prod_full[2*ex_pkg::xlen-1:0];
                s1_tag   <= issue.tag;
                s1_func3 <= issue.func3;
            end
            if (s1_valid) begin
                result.tag <= s1_tag;
                case (s1_func3)
                    ex_pkg::f3_mulh,
                    ex_pkg::f3_mulhsu,
                    ex_pkg::f3_mulhu: result.value <= s1_prod[2*ex_pkg::xlen-1:ex_pkg::xlen];
                    default:          result.value <= s1_prod[ex_pkg::xlen-1:0];
                endcase
            end
        end
    end

endmodule

// ==== ex_result_merge.sv ====
`timescale 1ns/10ps

module ex_result_merge (
    input  logic                      clk,
    input  logic                      reset,
    ex_result_if.dst                  alu_res,
    ex_result_if.dst                  mul_res,
    output logic                      wb_valid,
    output logic [ex_pkg::tag_w-1:0]  wb_tag,
    output logic [ex_pkg::xlen-1:0]   wb_value,
    output logic                      wb_taken,
    output logic [ex_pkg::xlen-1:0]   wb_target
);

    typedef struct packed {
        logic [ex_pkg::tag_w-1:0] tag;
        logic [ex_pkg::xlen-1:0]  value;
        logic                     taken;
        logic [ex_pkg::xlen-1:0]  target;
    } wb_t;

    wb_t  alu_in, mul_in, hold_q, send, keep, wb_q;
    logic hold_valid;
    logic send_valid;
    logic keep_valid;  // Loser of this cycle goes to the hold slot

    assign alu_in = '{alu_res.tag, alu_res.value, alu_res.taken, alu_res.target};
    assign mul_in = '{mul_res.tag, mul_res.value, mul_res.taken, mul_res.target};

    always_comb begin
        send_valid = hold_valid || alu_res.valid || mul_res.valid;
        keep_valid = 1'b0;
        keep       = alu_in;
        if (hold_valid) begin  // Held entry has first claim
            send       = hold_q;
            keep_valid = alu_res.valid || mul_res.valid;
            keep       = mul_res.valid ? mul_in : alu_in;
        end else if (mul_res.valid) begin
            send       = mul_in;
            keep_valid = alu_res.valid;
        end else begin
            send       = alu_in;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_valid   <= 1'b0;
            wb_q       <= '0;
            hold_valid <= 1'b0;
            hold_q     <= '0;
        end else begin
            wb_valid   <= send_valid;
            hold_valid <= keep_valid;
            if (send_valid) wb_q <= send;
            if (keep_valid) hold_q <= keep;
        end
    end

    assign wb_tag    = wb_q.tag;
    assign wb_value  = wb_q.value;
    assign wb_taken  = wb_q.taken;
    assign wb_target = wb_q.target;

    // Single-issue spacing means a full hold slot never meets a second collision
    a_no_drop: assert property (@(posedge clk) disable iff (reset)
        hold_valid |-> !(alu_res.valid && mul_res.valid));

endmodule

// ==== ex_stage.sv ====
`timescale 1ns/10ps

module ex_stage (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       execute_on,
    input  logic [ex_pkg::op_w-1:0]    opcode,
    input  logic [ex_pkg::xlen-1:0]    operand1,
    input  logic [ex_pkg::xlen-1:0]    operand2,
    input  logic [ex_pkg::f3_w-1:0]    func3,
    input  logic [ex_pkg::xlen-1:0]    pc,
    input  logic [ex_pkg::xlen-1:0]    label,
    input  logic [ex_pkg::ctrl_w-1:0]  control,
    input  logic [ex_pkg::tag_w-1:0]   rd_tag,
    output logic                       wb_valid,
    output logic [ex_pkg::tag_w-1:0]   wb_tag,
    output logic [ex_pkg::xlen-1:0]    wb_value,
    output logic                       wb_taken,
    output logic [ex_pkg::xlen-1:0]    wb_target
);

    ex_issue_if  alu_issue ();
    ex_issue_if  mul_issue ();
    ex_result_if alu_res ();
    ex_result_if mul_res ();

    ex_dispatch u_dispatch (
        .clk, .reset, .execute_on, .opcode, .operand1, .operand2,
        .func3, .pc, .label, .control, .rd_tag,
        .alu_issue (alu_issue.src),
        .mul_issue (mul_issue.src)
    );

    int_alu u_int_alu (
        .clk, .reset,
        .issue  (alu_issue.dst),
        .result (alu_res.src)
    );

    mul_unit u_mul_unit (
        .clk, .reset,
        .issue  (mul_issue.dst),
        .result (mul_res.src)
    );

    ex_result_merge u_merge (
        .clk, .reset,
        .alu_res (alu_res.dst),
        .mul_res (mul_res.dst),
        .wb_valid, .wb_tag, .wb_value, .wb_taken, .wb_target
    );

endmodule

// ==== tb_ex_stage.sv ====
`timescale 1ns/10ps

module tb_ex_stage;

    localparam int max_cycles = 3000;  // About seven times the length of all tests
    localparam logic [6:0] op_alu = 7'b0010011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [31:0] sign_bit = 32'h8000_0000;

    logic clk, reset, execute_on, wb_valid, wb_taken;
    logic [ex_pkg::op_w-1:0] opcode;
    logic [ex_pkg::f3_w-1:0] func3;
    logic [ex_pkg::ctrl_w-1:0] control;
    logic [ex_pkg::tag_w-1:0] rd_tag, wb_tag;
    logic [ex_pkg::xlen-1:0] operand1, operand2, pc, label, wb_value, wb_target;

    logic [64:0] exp_res [256];  // {value, taken, target} per tag
    bit pending [256];
    bit is_mul [256];  // Multiplies win every collision and are never delayed
    int due [256];  // Earliest cycle the result may show
    int seq [256];  // Issue count including this instruction
    int adj [256];  // 1 when issued right behind another instruction
    int cyc = 0, n_issued = 0, n_done = 0, errors = 0, tests = 0, last_issue = -10;
    logic [31:0] rng = 32'h9b6a;
    logic [2:0] br_codes [6] = '{ex_pkg::f3_beq, ex_pkg::f3_bne, ex_pkg::f3_blt,
                                 ex_pkg::f3_bge, ex_pkg::f3_bltu, ex_pkg::f3_bgeu};

    ex_stage u_ex_stage (
        .clk, .reset, .execute_on, .opcode, .operand1, .operand2, .func3, .pc, .label,
        .control, .rd_tag, .wb_valid, .wb_tag, .wb_value, .wb_taken, .wb_target
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= max_cycles) begin
            $display("Timeout: the run went past %0d cycles without finishing", max_cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (!reset && wb_valid) begin  // Retire the tag once seen
            pending[wb_tag] <= 1'b0;
            n_done <= n_done + 1;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    function automatic logic [31:0] next_random();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic logic [31:0] corner(input int k);
        case (k % 5)
            0: return 32'h0;
            1: return 32'hffff_ffff;
            2: return sign_bit;
            3: return 32'd31;  // Largest shift amount
            default: return next_random();
        endcase
    endfunction

    function automatic logic [6:0] ctrl_bits(input logic br, input logic alt);
        logic [6:0] c;
        c = '0;
        c[ex_pkg::ctrl_branch] = br;
        c[ex_pkg::ctrl_alt] = alt;
        return c;
    endfunction

    // Expected {value, taken, target}; signed compares flip the sign bit
    function automatic logic [64:0] model(input logic [6:0] op, input logic [2:0] f3,
            input logic [6:0] ctrl, input logic [31:0] a, b, pcv, lab);
        logic [63:0] sa, sb, ua, ub, prod;
        logic [31:0] val;
        logic tk;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ua = {32'h0, a};
        ub = {32'h0, b};
        tk = 1'b0;
        if (op == ex_pkg::op_mul) begin
            case (f3)
                ex_pkg::f3_mulh: prod = sa * sb;
                ex_pkg::f3_mulhsu: prod = sa * ub;
                default: prod = ua * ub;
            endcase
            return {(f3 == ex_pkg::f3_mul) ? prod[31:0] : prod[63:32], 1'b0, 32'h0};
        end
        if (ctrl[ex_pkg::ctrl_branch]) begin
            case (f3)
                ex_pkg::f3_beq: tk = (a == b);
                ex_pkg::f3_bne: tk = (a != b);
                ex_pkg::f3_blt: tk = (a ^ sign_bit) < (b ^ sign_bit);
                ex_pkg::f3_bge: tk = (a ^ sign_bit) >= (b ^ sign_bit);
                ex_pkg::f3_bltu: tk = a < b;
                default: tk = a >= b;
            endcase
            return {pcv + 32'd4, tk, pcv + lab};
        end
        case (f3)
            ex_pkg::f3_add: val = ctrl[ex_pkg::ctrl_alt] ? a - b : a + b;
            ex_pkg::f3_sll: val = a << b[4:0];
            ex_pkg::f3_slt: val = {31'h0, (a ^ sign_bit) < (b ^ sign_bit)};
            ex_pkg::f3_sltu: val = {31'h0, a < b};
            ex_pkg::f3_xor: val = a ^ b;
            ex_pkg::f3_srl: val = (a >> b[4:0]) |
                ((ctrl[ex_pkg::ctrl_alt] && a[31]) ? ~(32'hffff_ffff >> b[4:0]) : 32'h0);
            ex_pkg::f3_or: val = a | b;
            default: val = a & b;
        endcase
        return {val, 1'b0, 32'h0};
    endfunction

    task automatic send_instr(input logic [6:0] op, input logic [2:0] f3,
                              input logic [6:0] ctrl, input logic [31:0] a, b);
        logic [31:0] pcv, lab;
        logic [7:0] t;
        pcv = next_random() & 32'hffff_fffc;
        lab = next_random() & 32'h0000_1ffe;  // Branch sized offset
        t = n_issued[7:0];
        @(negedge clk);
        execute_on = 1'b1;
        {opcode, func3, control, rd_tag} = {op, f3, ctrl, t};
        {operand1, operand2, pc, label} = {a, b, pcv, lab};
        exp_res[t] = model(op, f3, ctrl, a, b, pcv, lab);
        pending[t] = 1'b1;
        is_mul[t] = (op == ex_pkg::op_mul);
        due[t] = cyc + ((op == ex_pkg::op_mul) ? 4 : 3);  // Seen at the negedge after wb
        adj[t] = (last_issue == cyc - 1) ? 1 : 0;
        last_issue = cyc;
        n_issued = n_issued + 1;
        seq[t] = n_issued;
    endtask

    task automatic send_random();
        logic [31:0] r;
        logic [6:0] op, ctrl;
        logic [2:0] f3;
        r = next_random();
        op = r[0] ? ex_pkg::op_mul : ((r[7:1] == ex_pkg::op_mul) ? op_alu : r[7:1]);
        f3 = (op == ex_pkg::op_mul) ? {1'b0, r[9:8]} : r[10:8];
        ctrl = r[17:11];
        if (ctrl[ex_pkg::ctrl_branch] && f3[2:1] == 2'b01) ctrl[ex_pkg::ctrl_branch] = 1'b0;
        send_instr(op, f3, ctrl, next_random(), r[18] ? next_random() : corner(int'(r[21:19])));
    endtask

    task automatic idle(input int n);
        logic [31:0] r;
        repeat (n) begin
            @(negedge clk);
            r = next_random();
            execute_on = 1'b0;
            {opcode, func3, control, rd_tag} = r[24:0];  // Junk that must be ignored
            operand1 = r;
        end
    endtask

    task automatic finish_test(input string name);
        idle(1);
        while (n_done != n_issued) idle(1);
        tests = tests + 1;
        $display("%-14s finished at cycle %0d, errors so far %0d", name, cyc, errors);
    endtask

    a_tag_pending: assert property (@(negedge clk) disable iff (reset)
        wb_valid |-> pending[wb_tag])
        else begin
            errors = errors + 1;
            $display("Writeback at %0t carries tag %0d, which was not pending", $time, wb_tag);
        end

    a_wb_value: assert property (@(negedge clk) disable iff (reset)
        wb_valid |-> ({wb_value, wb_taken, wb_target} == exp_res[wb_tag]))
        else begin
            errors = errors + 1;
            $display("[FAIL] %0t tag %0d: got %h/%b/%h, expected %h/%b/%h", $time, wb_tag,
                     wb_value, wb_taken, wb_target, exp_res[wb_tag][64:33],
                     exp_res[wb_tag][32], exp_res[wb_tag][31:0]);
        end

    a_wb_window: assert property (@(negedge clk) disable iff (reset)
        wb_valid |-> (cyc >= due[wb_tag] &&
                      cyc <= due[wb_tag] + (is_mul[wb_tag] ? 0 :
                             n_issued - seq[wb_tag] + adj[wb_tag])))
        else begin
            errors = errors + 1;
            $display("Tag %0d written back at cycle %0d, outside its latency window",
                     wb_tag, cyc);
        end

    a_quiet_start: assert property (@(negedge clk) (reset || n_issued == 0) |-> !wb_valid)
        else begin
            errors = errors + 1;
            $display("Writeback valid at %0t before any instruction was issued", $time);
        end

    initial begin
        reset = 1'b1;
        execute_on = 1'b0;
        {opcode, func3, control, rd_tag} = '0;
        {operand1, operand2, pc, label} = '0;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        idle(3);
        send_instr(op_alu, ex_pkg::f3_add, 7'h0, 32'd100, 32'd23);
        finish_test("reset_add");
        for (int f = 0; f < 8; f++)
            for (int alt = 0; alt < 2; alt++)
                for (int k = 0; k < 5; k++)
                    send_instr(op_alu, f[2:0], ctrl_bits(1'b0, alt[0]), corner(k), corner(k + 3));
        finish_test("alu_ops");
        for (int i = 0; i < 6; i++)
            for (int k = 0; k < 7; k++)
                send_instr(op_branch, br_codes[i], ctrl_bits(1'b1, 1'b0), corner(k),
                           k[0] ? corner(k) : corner(k + 1));
        finish_test("branches");
        for (int f = 0; f < 4; f++)
            for (int k = 0; k < 5; k++)
                send_instr(ex_pkg::op_mul, f[2:0], 7'h0, corner(k), corner(k + 1));
        finish_test("mul_ops");
        send_instr(ex_pkg::op_mul, ex_pkg::f3_mulh, 7'h0, 32'hffff_fff9, 32'd6);
        finish_test("mul_single");
        send_instr(ex_pkg::op_mul, ex_pkg::f3_mul, 7'h0, 32'd1234, 32'd5678);
        send_instr(op_alu, ex_pkg::f3_add, 7'h0, 32'd1, 32'd2);  // Completes with the multiply
        finish_test("mul_then_add");
        repeat (200) send_random();
        finish_test("random_mix");
        idle(10);
        send_instr(7'b0000011, ex_pkg::f3_xor, 7'h0, corner(4), corner(4));
        send_instr(7'b1111111, ex_pkg::f3_sltu, ctrl_bits(1'b0, 1'b1), 32'd3, 32'hffff_ffff);
        finish_test("idle_odd_ops");
        for (int t = 0; t < 256; t++) begin
            if (pending[t]) begin
                errors = errors + 1;
                $display("Tag %0d was issued but never written back", t);
            end
        end
        $display("Summary: %0d tests, %0d issued, %0d written back, %0d errors",
                 tests, n_issued, n_done, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// ==== flist.f ====
ex_pkg.sv
ex_issue_if.sv
ex_result_if.sv
ex_dispatch.sv
int_alu.sv
mul_unit.sv
ex_result_merge.sv
ex_stage.sv
tb_ex_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the execute stage testbench with Verilator
verilator --binary --timing --assert -f flist.f --top-module tb_ex_stage \
    -o sim_ex_stage > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_ex_stage > sim.log 2>&1 ; cat sim.log
grep -q "Test FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "Test OK" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0
